//--- tb.f
+incdir+logic
logic/ctrlPkg.sv
logic/commutePkg.sv
logic/phaseBus.sv
logic/commandCapture.sv
logic/commutationSequencer.sv
logic/pwmCarrier.sv
logic/gateDriver.sv
logic/motorDriveTop.sv
bench/motorDriveTb.sv

//--- Bender.yml
package:
  name: motor_drive

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/ctrlPkg.sv
      - logic/commutePkg.sv
      - logic/phaseBus.sv
      - logic/commandCapture.sv
      - logic/commutationSequencer.sv
      - logic/pwmCarrier.sv
      - logic/gateDriver.sv
      - logic/motorDriveTop.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/motorDriveTb.sv

//--- bench/motorDriveTb.sv
`timescale 1ns/10ps
`include "motor_defines.svh"

module motorDriveTb import commutePkg::*; ();

    localparam int          NUM_SEGS  = 10;
    localparam logic [31:0] LFSR_SEED = 32'he010e026;

    logic               clk;
    logic               nRst;
    logic               start;
    logic               invOrStop;
    logic [`FREQ_W-1:0] freq;
    logic               aHP, aLN, bHP, bLN, cHP, cLN;

    logic [31:0]        lfsrState;
    int                 cycleCount = 0;
    int                 cycleLimit = 0;     // Zero until the segments are known

    logic               segStart [NUM_SEGS];
    logic               segInv [NUM_SEGS];
    logic [`FREQ_W-1:0] segFreq [NUM_SEGS];
    int                 segCycles [NUM_SEGS];

    // Reference model state, as it stands after the latest rising edge
    logic        mRun, mRev, mBrake, mRunning;
    int          mPeriod, mAge, mLen, mCarrier;
    stepIdxT     mStep;
    gatePatternT mOn;                       // Switches that should be on, 1 means on

    motorDriveTop uut (
        .clk       (clk),
        .nRst      (nRst),
        .start     (start),
        .invOrStop (invOrStop),
        .freq      (freq),
        .aHP       (aHP),
        .aLN       (aLN),
        .bHP       (bHP),
        .bLN       (bLN),
        .cHP       (cHP),
        .cLN       (cLN)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("The run did not finish within %0d cycles and seems to hang", cycleLimit);
            stopRun();
        end
    end

    // ************************************************************
    // Random numbers and helpers
    // ************************************************************

    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic int clampPeriod(input logic [`FREQ_W-1:0] f);
        return (f <= `MIN_STEP_PERIOD) ? `MIN_STEP_PERIOD : int'(f);
    endfunction

    // Bits in order aH aL bH bL cH cL
    function automatic gatePatternT expectedPattern(input stepIdxT idx);
        case (idx)
            STEP0:   return 6'b100001;
            STEP1:   return 6'b001001;
            STEP2:   return 6'b011000;
            STEP3:   return 6'b010010;
            STEP4:   return 6'b000110;
            STEP5:   return 6'b100100;
            default: return 6'b000000;
        endcase
    endfunction

    function automatic gatePatternT pinsOn();
        return gatePatternT'({aHP, aLN ^ `LOW_SIDE_ACTIVE_LOW, bHP, bLN ^ `LOW_SIDE_ACTIVE_LOW,
                              cHP, cLN ^ `LOW_SIDE_ACTIVE_LOW});
    endfunction

    task automatic stopRun();
        $display("Checks failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic checkPins(input gatePatternT actual, input gatePatternT expected,
                             input string what);
        if (actual !== expected) begin
            $display("error %0t ns: %s are %b, expected %b", $time, what, actual, expected);
            stopRun();
        end
    endtask

    task automatic checkStep(input stepIdxT actual, input stepIdxT expected, input string what);
        if (actual !== expected) begin
            $display("error %0t ns: %s is %s, expected %s", $time, what, actual.name(),
                     expected.name());
            stopRun();
        end
    endtask

    task automatic checkLegs(input gatePatternT actual);
        if ((actual.aH && actual.aL) || (actual.bH && actual.bL) || (actual.cH && actual.cL)) begin
            $display("error %0t ns: shoot-through on a leg, gates on %b", $time, actual);
            stopRun();
        end
    endtask

    // ************************************************************
    // Stimulus plan and reference model
    // ************************************************************

    task automatic buildSegments();
        int steps;
        int total;
        total = 0;
        for (int s = 0; s < NUM_SEGS; s++) begin
            case (s)
                0:       {segStart[s], segInv[s]} = 2'b00;  // Coast out of reset
                1:       {segStart[s], segInv[s]} = 2'b10;  // Forward
                2:       {segStart[s], segInv[s]} = 2'b11;  // Reverse without stopping
                3:       {segStart[s], segInv[s]} = 2'b01;  // Brake
                default: {segStart[s], segInv[s]} = 2'(randomBits(2));
            endcase
            if (randomBits(1)) begin
                segFreq[s] = `FREQ_W'(1008 + randomBits(4));
            end else begin
                segFreq[s] = `FREQ_W'(randomBits(`FREQ_W));
            end
            steps        = 2 + int'(randomBits(2)) % 3;
            segCycles[s] = steps * clampPeriod(segFreq[s]);
            total        = total + segCycles[s];
        end
        cycleLimit = total + 1000;
    endtask

    task automatic resetModel();
        {mRun, mRev, mBrake, mRunning} = 4'b0000;
        mPeriod  = `MIN_STEP_PERIOD;
        mAge     = 0;
        mLen     = `MIN_STEP_PERIOD;
        mCarrier = 0;
        mStep    = STEP0;
        mOn      = '0;
    endtask

    // Moves the model across the next rising edge with the inputs now applied
    task automatic advanceModel();
        gatePatternT want;
        logic        chopNow;
        chopNow = (mCarrier < `PWM_DUTY);
        if (mBrake) begin
            want = 6'b010101;
        end else if (mRun && mRunning && chopNow) begin
            want = expectedPattern(mStep);
        end else begin
            want = '0;
        end
        if (mRun && !mRunning) begin
            mStep = STEP0;
            mAge  = 0;
            mLen  = mPeriod;
        end else if (mRunning) begin
            if (mAge == mLen - 1) begin
                mStep = mRev ? stepIdxT'((int'(mStep) + 5) % 6) : stepIdxT'((int'(mStep) + 1) % 6);
                mAge  = 0;
                mLen  = mPeriod;
            end else begin
                mAge++;
            end
        end
        mRunning = mRun;
        mCarrier = (mCarrier == `PWM_PERIOD - 1) ? 0 : mCarrier + 1;
        mRun     = start;
        mRev     = start && invOrStop;
        mBrake   = !start && invOrStop;
        mPeriod  = clampPeriod(freq);
        mOn      = want;
    endtask

    initial begin
        clk       = 1'b0;
        nRst      = 1'b0;
        start     = 1'b0;
        invOrStop = 1'b0;
        freq      = '0;
        lfsrState = LFSR_SEED;
        buildSegments();
        resetModel();
        repeat (8) @(negedge clk);
        nRst = 1'b1;
        checkPins(pinsOn(), '0, "gates after reset");
        for (int s = 0; s < NUM_SEGS; s++) begin
            start     = segStart[s];
            invOrStop = segInv[s];
            freq      = segFreq[s];
            for (int c = 0; c < segCycles[s]; c++) begin
                advanceModel();
                @(negedge clk);
                checkLegs(pinsOn());
                checkPins(pinsOn(), mOn, "gate pins");
                checkStep(uut.uSequencer.stepIdx, mStep, "step index");
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- logic/motorDriveTop.sv
`timescale 1ns/10ps
`include "motor_defines.svh"

module motorDriveTop import ctrlPkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  logic               start,
    input  logic               invOrStop,
    input  logic [`FREQ_W-1:0] freq,
    output logic               aHP,
    output logic               aLN,
    output logic               bHP,
    output logic               bLN,
    output logic               cHP,
    output logic               cLN
);

    driveCmdT cmd;

    phaseBus bus ();

    // ************************************************************
    // Pipeline stages
    // ************************************************************

    commandCapture uCapture (
        .clk       (clk),
        .nRst      (nRst),
        .start     (start),
        .invOrStop (invOrStop),
        .freq      (freq),
        .cmd       (cmd)
    );

    commutationSequencer uSequencer (
        .clk  (clk),
        .nRst (nRst),
        .cmd  (cmd),
        .bus  (bus.source)
    );

    pwmCarrier uCarrier (
        .clk  (clk),
        .nRst (nRst),
        .bus  (bus.source)
    );

    gateDriver uGate (
        .clk  (clk),
        .nRst (nRst),
        .cmd  (cmd),
        .bus  (bus.sink),
        .aHP  (aHP),
        .aLN  (aLN),
        .bHP  (bHP),
        .bLN  (bLN),
        .cHP  (cHP),
        .cLN  (cLN)
    );

endmodule

//--- logic/gateDriver.sv
`timescale 1ns/10ps
`include "motor_defines.svh"

module gateDriver import ctrlPkg::*, commutePkg::*; (
    input  logic     clk,
    input  logic     nRst,
    input  driveCmdT cmd,
    phaseBus.sink    bus,
    output logic     aHP,
    output logic     aLN,
    output logic     bHP,
    output logic     bLN,
    output logic     cHP,
    output logic     cLN
);

    gatePatternT drive;     // Switches to turn on next cycle, 1 means on

    always_comb begin
        if (cmd.brake) begin
            drive = '{aH: 1'b0, aL: 1'b1, bH: 1'b0, bL: 1'b1, cH: 1'b0, cL: 1'b1};
        end else if (cmd.run && bus.chop) begin
            drive = bus.pattern;
        end else begin
            drive = '0;                                 // Coast or chop off
        end
    end

    // ************************************************************
    // Gate pin registers
    // ************************************************************

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            aHP <= 1'b0;
            bHP <= 1'b0;
            cHP <= 1'b0;
            aLN <= 1'b0 ^ `LOW_SIDE_ACTIVE_LOW;
            bLN <= 1'b0 ^ `LOW_SIDE_ACTIVE_LOW;
            cLN <= 1'b0 ^ `LOW_SIDE_ACTIVE_LOW;
        end else begin
            aHP <= drive.aH;
            bHP <= drive.bH;
            cHP <= drive.cH;
            aLN <= drive.aL ^ `LOW_SIDE_ACTIVE_LOW;
            bLN <= drive.bL ^ `LOW_SIDE_ACTIVE_LOW;
            cLN <= drive.cL ^ `LOW_SIDE_ACTIVE_LOW;
        end
    end

    // No leg may conduct from both sides at once
    assert property (@(posedge clk) disable iff (!nRst)
        !(aHP && (aLN ^ `LOW_SIDE_ACTIVE_LOW))
        && !(bHP && (bLN ^ `LOW_SIDE_ACTIVE_LOW))
        && !(cHP && (cLN ^ `LOW_SIDE_ACTIVE_LOW)));

endmodule

//--- logic/pwmCarrier.sv
`timescale 1ns/10ps
`include "motor_defines.svh"

module pwmCarrier (
    input  logic    clk,
    input  logic    nRst,
    phaseBus.source bus
);

    localparam int CNT_W = $clog2(`PWM_PERIOD);

    logic [CNT_W-1:0] carrierCnt;

    // Free running, no enable, so the chop phase depends only on reset
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            carrierCnt <= '0;
        end else if (carrierCnt == CNT_W'(`PWM_PERIOD - 1)) begin
            carrierCnt <= '0;
        end else begin
            carrierCnt <= carrierCnt + 1'b1;
        end
    end

    assign bus.chop = (carrierCnt < CNT_W'(`PWM_DUTY));    // On part sits at the start of the period

endmodule

//--- logic/commutationSequencer.sv
`timescale 1ns/10ps

module commutationSequencer import ctrlPkg::*, commutePkg::*; (
    input  logic     clk,
    input  logic     nRst,
    input  driveCmdT cmd,
    phaseBus.source  bus
);

    logic        running;   // Run as seen last cycle, detects the start edge
    logic        runRise;
    stepIdxT     stepIdx;
    stepIdxT     nextIdx;
    stepPeriodT  stepTimer; // Cycles left in the current step, minus one

    assign runRise = cmd.run & ~running;

    // Direction is looked at only when a step ends
    always_comb begin
        if (cmd.reverse) begin
            nextIdx = (stepIdx == STEP0) ? STEP5 : stepIdxT'(stepIdx - 3'd1);
        end else begin
            nextIdx = (stepIdx == STEP5) ? STEP0 : stepIdxT'(stepIdx + 3'd1);
        end
    end

    // ************************************************************
    // Step timer and step counter
    // ************************************************************

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            running   <= 1'b0;
            stepIdx   <= STEP0;
            stepTimer <= '0;
        end else begin
            running <= cmd.run;
            if (runRise) begin
                stepIdx   <= STEP0;                                 // Every start begins at step 0
                stepTimer <= stepPeriodT'(cmd.stepPeriod - 1'b1);
            end else if (running) begin
                if (stepTimer == '0) begin
                    stepIdx   <= nextIdx;
                    stepTimer <= stepPeriodT'(cmd.stepPeriod - 1'b1);
                end else begin
                    stepTimer <= stepTimer - 1'b1;
                end
            end
        end
    end

    assign bus.pattern = running ? stepPattern(stepIdx) : '0;

    // ************************************************************
    // Checks
    // ************************************************************

    // One high and one low switch on, never on the same leg
    assert property (@(posedge clk) disable iff (!nRst)
        running |-> $onehot({bus.pattern.aH, bus.pattern.bH, bus.pattern.cH})
                 && $onehot({bus.pattern.aL, bus.pattern.bL, bus.pattern.cL})
                 && !(bus.pattern.aH && bus.pattern.aL)
                 && !(bus.pattern.bH && bus.pattern.bL)
                 && !(bus.pattern.cH && bus.pattern.cL));

endmodule

//--- logic/commandCapture.sv
`timescale 1ns/10ps
`include "motor_defines.svh"

module commandCapture import ctrlPkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  logic               start,
    input  logic               invOrStop,
    input  logic [`FREQ_W-1:0] freq,
    output driveCmdT           cmd
);

    stepPeriodT clampedPeriod;

    // Anything at or under the floor runs at the floor
    always_comb begin
        if (freq <= stepPeriodT'(`MIN_STEP_PERIOD)) begin
            clampedPeriod = stepPeriodT'(`MIN_STEP_PERIOD);
        end else begin
            clampedPeriod = freq;
        end
    end

    // ************************************************************
    // Input register
    // ************************************************************

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            cmd.run        <= 1'b0;
            cmd.reverse    <= 1'b0;
            cmd.brake      <= 1'b0;
            cmd.stepPeriod <= stepPeriodT'(`MIN_STEP_PERIOD);
        end else begin
            cmd.run        <= start;
            cmd.reverse    <= start & invOrStop;    // Direction only matters while running
            cmd.brake      <= ~start & invOrStop;   // Same pin means brake when stopped
            cmd.stepPeriod <= clampedPeriod;
        end
    end

endmodule

//--- logic/phaseBus.sv
`timescale 1ns/10ps

interface phaseBus import commutePkg::*; ();

    gatePatternT pattern;   // Switches the current step wants on
    logic        chop;      // PWM carrier, high during the on part

    // Sequencer and carrier each drive their own signal
    modport source (
        output pattern,
        output chop
    );

    modport sink (
        input pattern,
        input chop
    );

endinterface

//--- logic/commutePkg.sv
package commutePkg;

    typedef enum logic [2:0] {
        STEP0 = 3'd0,
        STEP1 = 3'd1,
        STEP2 = 3'd2,
        STEP3 = 3'd3,
        STEP4 = 3'd4,
        STEP5 = 3'd5
    } stepIdxT;

    // One bit per switch, 1 means the FET is on
    typedef struct packed {
        logic aH;
        logic aL;
        logic bH;
        logic bL;
        logic cH;
        logic cL;
    } gatePatternT;

    function automatic gatePatternT stepPattern(stepIdxT idx);
        gatePatternT p;
        p = '0;
        case (idx)
            STEP0: begin p.aH = 1'b1; p.cL = 1'b1; end
            STEP1: begin p.bH = 1'b1; p.cL = 1'b1; end
            STEP2: begin p.bH = 1'b1; p.aL = 1'b1; end
            STEP3: begin p.cH = 1'b1; p.aL = 1'b1; end
            STEP4: begin p.cH = 1'b1; p.bL = 1'b1; end
            STEP5: begin p.aH = 1'b1; p.bL = 1'b1; end
            default: p = '0;                            // Unused codes keep every switch off
        endcase
        return p;
    endfunction

endpackage

//--- logic/ctrlPkg.sv
`include "motor_defines.svh"

package ctrlPkg;

    // Length of one commutation step in clock cycles
    typedef logic [`FREQ_W-1:0] stepPeriodT;

    // Operator command after capture
    typedef struct packed {
        logic       run;        // Motor is commutating
        logic       reverse;    // Reverse step order while running
        logic       brake;      // All low sides on while stopped
        stepPeriodT stepPeriod; // Already clamped to the minimum
    } driveCmdT;

endpackage

//--- logic/motor_defines.svh
`ifndef MOTOR_DEFINES_SVH
`define MOTOR_DEFINES_SVH

// ************************************************************
// Command limits
// ************************************************************

`define FREQ_W              10      // Width of the step period input
`define MIN_STEP_PERIOD     1000    // Shortest commutation step in clocks

// ************************************************************
// PWM carrier
// ************************************************************

`define PWM_PERIOD          100     // Carrier length in clocks
`define PWM_DUTY            60      // Chop high for this many clocks of each period

// ************************************************************
// Gate polarity
// ************************************************************

`define LOW_SIDE_ACTIVE_LOW 1'b1    // Low-side pins drive 0 to switch the FET on

`endif
